//--- Makefile
# Verilator build and run for the commit unit testbench

TOP = tb_commit_unit
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hw/arch_rat.sv
// architectural register alias table

`timescale 1ns/100ps

module arch_rat import commit_pkg::*; (
  input  logic                                clk,
  input  logic                                rst_n,
  commit_if.rat_mp                            cmt,
  input  logic [ARCH_REG_W-1:0]               rat_raddr_i,
  output logic [PREG_W-1:0]                   rat_rdata_o,
  output logic [COMMIT_WIDTH-1:0]             free_valid_o,
  output logic [COMMIT_WIDTH-1:0][PREG_W-1:0] free_preg_o
);

  logic [PREG_W-1:0]       rat_q [ARCH_REG_NUM];
  logic [COMMIT_WIDTH-1:0] wr_en;

  // r0 is hardwired, never renamed
  always_comb begin
    for (int s = 0; s < COMMIT_WIDTH; s++) begin
      wr_en[s] = cmt.valid[s] & (cmt.entry[s].arch_reg != '0);
    end
  end

  // ================================================
  // table update
  // ================================================
  // later slots are younger, so the last write in the loop wins
  always_ff @(posedge clk or negedge rst_n) begin
    if (~rst_n) begin
      for (int i = 0; i < ARCH_REG_NUM; i++) begin
        rat_q[i] <= PREG_W'(i);
      end
    end else begin
      for (int s = 0; s < COMMIT_WIDTH; s++) begin
        if (wr_en[s]) begin
          rat_q[cmt.entry[s].arch_reg] <= cmt.entry[s].phy_reg;
        end
      end
    end
  end

  assign rat_rdata_o = rat_q[rat_raddr_i];

  // previous mapping goes back to the free list
  always_comb begin
    for (int s = 0; s < COMMIT_WIDTH; s++) begin
      free_valid_o[s] = wr_en[s];
      free_preg_o[s]  = cmt.entry[s].old_phy_reg;
    end
  end

  // rename must never hand out the register it is replacing
  for (genvar s = 0; s < COMMIT_WIDTH; s++) begin : g_free_chk
    a_free_not_new: assert property (
      @(posedge clk) disable iff (!rst_n)
      wr_en[s] |-> cmt.entry[s].old_phy_reg != cmt.entry[s].phy_reg
    ) else $error("slot %0d frees the register it writes", s);
  end

endmodule

//--- hw/commit_flush_ctrl.sv
// commit flush control

`timescale 1ns/100ps

module commit_flush_ctrl import commit_pkg::*; (
  commit_if.flush_mp cmt,
  input  logic [31:0] csr_eentry_i,
  input  logic [31:0] csr_tlbrentry_i,
  input  logic [31:0] csr_era_i,
  output logic        flush_o,
  output logic [31:0] target_o,
  output logic        idle_commit_o,
  output logic        excp_commit_o,
  output logic        tlbrefill_o,
  output logic        ertn_o,
  output logic [31:0] era_o,
  output ecode_e      ecode_o,
  output logic        va_error_o,
  output logic [31:0] bad_va_o,
  output logic        excp_tlb_o
);

  cmt_entry_t e0;
  logic       v0;
  logic       redirect_flush;
  logic       refetch_flush;

  assign v0 = cmt.valid[0];
  assign e0 = cmt.entry[0];

  // ================================================
  // flush classification of the oldest entry
  // ================================================
  assign excp_commit_o  = v0 & e0.excp_valid;
  assign tlbrefill_o    = excp_commit_o & (e0.ecode == TLBR);
  assign redirect_flush = v0 & e0.br_redirect;
  assign ertn_o         = v0 & (e0.kind == ERTN);
  // ibar, priv, cache op and idle all restart at the next instruction
  assign refetch_flush  = v0 & (e0.kind inside {IBAR, PRIV, ICACOP, IDLE});
  assign idle_commit_o  = v0 & (e0.kind == IDLE);

  assign flush_o = excp_commit_o | redirect_flush | ertn_o | refetch_flush;

  // restart address, highest priority first
  always_comb begin
    if (tlbrefill_o) begin
      target_o = csr_tlbrentry_i;
    end else if (excp_commit_o) begin
      target_o = csr_eentry_i;
    end else if (redirect_flush) begin
      target_o = e0.br_target;
    end else if (ertn_o) begin
      target_o = csr_era_i;
    end else begin
      target_o = e0.pc + 32'd4;
    end
  end

  // ================================================
  // exception report to the CSR block
  // ================================================
  // syscall and break return past the trapping instruction
  assign era_o    = (e0.ecode inside {SYS, BRK}) ? e0.pc + 32'd4 : e0.pc;
  assign ecode_o  = e0.ecode;
  assign bad_va_o = e0.bad_vaddr;

  assign va_error_o = excp_commit_o &
                      (e0.ecode inside {ADE, TLBR, PIF, PPI, ALE, PME, PIS, PIL});
  // address faults that came from a TLB lookup
  assign excp_tlb_o = excp_commit_o &
                      (e0.ecode inside {TLBR, PIF, PPI, PME, PIS, PIL});

  // the reorder buffer never pairs a flushing entry with a younger one
  always_comb begin
    assert #0 (!flush_o || !cmt.valid[1])
      else $error("flush while slot 1 retires");
    assert #0 (!flush_o || target_o[1:0] == 2'b00)
      else $error("restart target not word aligned");
  end

endmodule

//--- hw/commit_if.sv
// commit slot bus

`timescale 1ns/100ps

interface commit_if import commit_pkg::*; ();

  // one valid bit and one entry per retire slot
  logic       [COMMIT_WIDTH-1:0] valid;
  cmt_entry_t [COMMIT_WIDTH-1:0] entry;

  // flush control only looks at the oldest slot
  modport flush_mp (
    input valid,
    input entry
  );

  // alias table consumes every slot
  modport rat_mp (
    input valid,
    input entry
  );

endinterface

//--- hw/commit_pkg.sv
// commit stage shared definitions

package commit_pkg;

  // ================================================
  // widths and constants
  // ================================================
  localparam int COMMIT_WIDTH = 2;
  localparam int ARCH_REG_NUM = 32;
  localparam int ARCH_REG_W   = $clog2(ARCH_REG_NUM);
  localparam int PHY_REG_NUM  = 64;
  localparam int PREG_W       = $clog2(PHY_REG_NUM);

  // bytes per fetch step
  localparam int unsigned FETCH_BYTES = 16;

  localparam logic [31:0] RESET_PC = 32'h1c00_0000;

  // ================================================
  // exception causes
  // ================================================
  typedef enum logic [5:0] {
    INT  = 6'h00,
    PIL  = 6'h01,
    PIS  = 6'h02,
    PIF  = 6'h03,
    PME  = 6'h04,
    PPI  = 6'h07,
    ADE  = 6'h08,
    ALE  = 6'h09,
    SYS  = 6'h0b,
    BRK  = 6'h0c,
    INE  = 6'h0d,
    TLBR = 6'h3f
  } ecode_e;

  // extra work a retiring instruction asks for
  typedef enum logic [2:0] {
    NORMAL = 3'd0,
    ERTN   = 3'd1,
    IBAR   = 3'd2,
    PRIV   = 3'd3,
    ICACOP = 3'd4,
    IDLE   = 3'd5
  } cmt_kind_e;

  // ================================================
  // one retiring reorder buffer entry
  // ================================================
  typedef struct packed {
    logic [31:0]           pc;
    logic [ARCH_REG_W-1:0] arch_reg;
    logic [PREG_W-1:0]     phy_reg;
    logic [PREG_W-1:0]     old_phy_reg;
    logic                  excp_valid;
    ecode_e                ecode;
    logic                  br_redirect;
    logic [31:0]           br_target;
    cmt_kind_e             kind;
    logic [31:0]           bad_vaddr;
  } cmt_entry_t;

endpackage

//--- hw/commit_unit_top.sv
// commit unit top level

`timescale 1ns/100ps

module commit_unit_top import commit_pkg::*; (
  input  logic                                    clk,
  input  logic                                    rst_n,
  // per-slot retire info
  input  logic [COMMIT_WIDTH-1:0]                 cmt_valid_i,
  input  logic [COMMIT_WIDTH-1:0][31:0]           cmt_pc_i,
  input  logic [COMMIT_WIDTH-1:0][ARCH_REG_W-1:0] cmt_arch_reg_i,
  input  logic [COMMIT_WIDTH-1:0][PREG_W-1:0]     cmt_phy_reg_i,
  input  logic [COMMIT_WIDTH-1:0][PREG_W-1:0]     cmt_old_phy_reg_i,
  // oldest slot only
  input  logic                                    cmt_excp_valid_i,
  input  ecode_e                                  cmt_ecode_i,
  input  logic                                    cmt_br_redirect_i,
  input  logic [31:0]                             cmt_br_target_i,
  input  cmt_kind_e                               cmt_kind_i,
  input  logic [31:0]                             cmt_bad_vaddr_i,
  // CSR side
  input  logic [31:0]                             csr_eentry_i,
  input  logic [31:0]                             csr_tlbrentry_i,
  input  logic [31:0]                             csr_era_i,
  input  logic                                    csr_has_int_i,
  input  logic                                    fetch_ready_i,
  input  logic [ARCH_REG_W-1:0]                   rat_raddr_i,
  output logic                                    flush_o,
  output logic                                    fetch_valid_o,
  output logic [31:0]                             fetch_pc_o,
  output logic                                    excp_commit_o,
  output logic                                    tlbrefill_o,
  output logic                                    ertn_o,
  output logic [31:0]                             era_o,
  output ecode_e                                  ecode_o,
  output logic                                    va_error_o,
  output logic [31:0]                             bad_va_o,
  output logic                                    excp_tlb_o,
  output logic [PREG_W-1:0]                       rat_rdata_o,
  output logic [COMMIT_WIDTH-1:0]                 free_valid_o,
  output logic [COMMIT_WIDTH-1:0][PREG_W-1:0]     free_preg_o
);

  cmt_entry_t [COMMIT_WIDTH-1:0] slot_entry;
  logic [31:0]                   flush_target;
  logic                          idle_commit;

  commit_if cmt_if ();

  // ================================================
  // pack plain ports onto the commit bus
  // ================================================
  always_comb begin
    for (int s = 0; s < COMMIT_WIDTH; s++) begin
      slot_entry[s].pc          = cmt_pc_i[s];
      slot_entry[s].arch_reg    = cmt_arch_reg_i[s];
      slot_entry[s].phy_reg     = cmt_phy_reg_i[s];
      slot_entry[s].old_phy_reg = cmt_old_phy_reg_i[s];
      slot_entry[s].excp_valid  = 1'b0;
      slot_entry[s].ecode       = INT;
      slot_entry[s].br_redirect = 1'b0;
      slot_entry[s].br_target   = '0;
      slot_entry[s].kind        = NORMAL;
      slot_entry[s].bad_vaddr   = '0;
    end
    // flush info only exists for the oldest slot
    slot_entry[0].excp_valid  = cmt_excp_valid_i;
    slot_entry[0].ecode       = cmt_ecode_i;
    slot_entry[0].br_redirect = cmt_br_redirect_i;
    slot_entry[0].br_target   = cmt_br_target_i;
    slot_entry[0].kind        = cmt_kind_i;
    slot_entry[0].bad_vaddr   = cmt_bad_vaddr_i;
  end

  assign cmt_if.valid = cmt_valid_i;
  assign cmt_if.entry = slot_entry;

  commit_flush_ctrl u_flush_ctrl (
    .cmt             (cmt_if.flush_mp),
    .csr_eentry_i    (csr_eentry_i),
    .csr_tlbrentry_i (csr_tlbrentry_i),
    .csr_era_i       (csr_era_i),
    .flush_o         (flush_o),
    .target_o        (flush_target),
    .idle_commit_o   (idle_commit),
    .excp_commit_o   (excp_commit_o),
    .tlbrefill_o     (tlbrefill_o),
    .ertn_o          (ertn_o),
    .era_o           (era_o),
    .ecode_o         (ecode_o),
    .va_error_o      (va_error_o),
    .bad_va_o        (bad_va_o),
    .excp_tlb_o      (excp_tlb_o)
  );

  fetch_pc_gen u_fetch_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_o),
    .target_i      (flush_target),
    .idle_commit_i (idle_commit),
    .csr_has_int_i (csr_has_int_i),
    .fetch_ready_i (fetch_ready_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_pc_o    (fetch_pc_o)
  );

  arch_rat u_arch_rat (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmt          (cmt_if.rat_mp),
    .rat_raddr_i  (rat_raddr_i),
    .rat_rdata_o  (rat_rdata_o),
    .free_valid_o (free_valid_o),
    .free_preg_o  (free_preg_o)
  );

endmodule

//--- hw/fetch_pc_gen.sv
// fetch address generator

`timescale 1ns/100ps

module fetch_pc_gen import commit_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush_i,
  input  logic [31:0] target_i,
  input  logic        idle_commit_i,
  input  logic        csr_has_int_i,
  input  logic        fetch_ready_i,
  output logic        fetch_valid_o,
  output logic [31:0] fetch_pc_o
);

  logic [31:0] pc_q;
  logic        idle_lock;

  // ================================================
  // fetch address register
  // ================================================
  // redirect wins over back-pressure
  always_ff @(posedge clk or negedge rst_n) begin
    if (~rst_n) begin
      pc_q <= RESET_PC;
    end else if (flush_i) begin
      pc_q <= target_i;
    end else if (fetch_valid_o && fetch_ready_i) begin
      pc_q <= pc_q + 32'(FETCH_BYTES);
    end
  end

  // idle waits here until an interrupt arrives
  always_ff @(posedge clk or negedge rst_n) begin
    if (~rst_n) begin
      idle_lock <= 1'b0;
    end else if (flush_i && idle_commit_i && !csr_has_int_i) begin
      idle_lock <= 1'b1;
    end else if (csr_has_int_i) begin
      idle_lock <= 1'b0;
    end
  end

  assign fetch_valid_o = ~idle_lock;
  assign fetch_pc_o    = pc_q;

  // a locked front end only moves on a redirect
  a_idle_holds_pc: assert property (
    @(posedge clk) disable iff (!rst_n)
    idle_lock && !flush_i |=> $stable(fetch_pc_o)
  ) else $error("fetch address moved while idle");

endmodule

//--- testbench/tb_commit_unit.sv
// commit unit testbench

`timescale 1ns/100ps

module tb_commit_unit import commit_pkg::*; ();

  localparam int MAX_CYCLES = 2000;
  localparam ecode_e CAUSES [12] = '{INT, PIL, PIS, PIF, PME, PPI,
                                     ADE, ALE, SYS, BRK, INE, TLBR};

  logic                                    clk;
  logic                                    rst_n;
  logic [COMMIT_WIDTH-1:0]                 cmt_valid_i;
  logic [COMMIT_WIDTH-1:0][31:0]           cmt_pc_i;
  logic [COMMIT_WIDTH-1:0][ARCH_REG_W-1:0] cmt_arch_reg_i;
  logic [COMMIT_WIDTH-1:0][PREG_W-1:0]     cmt_phy_reg_i;
  logic [COMMIT_WIDTH-1:0][PREG_W-1:0]     cmt_old_phy_reg_i;
  logic                                    cmt_excp_valid_i;
  ecode_e                                  cmt_ecode_i;
  logic                                    cmt_br_redirect_i;
  logic [31:0]                             cmt_br_target_i;
  cmt_kind_e                               cmt_kind_i;
  logic [31:0]                             cmt_bad_vaddr_i;
  logic [31:0]                             csr_eentry_i;
  logic [31:0]                             csr_tlbrentry_i;
  logic [31:0]                             csr_era_i;
  logic                                    csr_has_int_i;
  logic                                    fetch_ready_i;
  logic [ARCH_REG_W-1:0]                   rat_raddr_i;
  logic                                    flush_o;
  logic                                    fetch_valid_o;
  logic [31:0]                             fetch_pc_o;
  logic                                    excp_commit_o;
  logic                                    tlbrefill_o;
  logic                                    ertn_o;
  logic [31:0]                             era_o;
  ecode_e                                  ecode_o;
  logic                                    va_error_o;
  logic [31:0]                             bad_va_o;
  logic                                    excp_tlb_o;
  logic [PREG_W-1:0]                       rat_rdata_o;
  logic [COMMIT_WIDTH-1:0]                 free_valid_o;
  logic [COMMIT_WIDTH-1:0][PREG_W-1:0]     free_preg_o;

  // reference model state
  logic                    exp_excp;
  logic                    exp_refill;
  logic                    exp_ertn;
  logic                    exp_flush;
  logic                    exp_va;
  logic                    exp_tlb;
  logic [31:0]             exp_era;
  logic [31:0]             exp_target;
  logic [COMMIT_WIDTH-1:0] exp_free;
  logic [31:0]             model_pc;
  logic                    model_lock;
  logic [PREG_W-1:0]       model_rat [ARCH_REG_NUM];
  int                      errors = 0;
  int                      cycles = 0;

  commit_unit_top UUT (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  // causes that carry a faulting virtual address
  function automatic logic va_cause(input ecode_e c);
    case (c)
      ADE, ALE, TLBR, PIF, PPI, PME, PIS, PIL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // ================================================
  // expected responses
  // ================================================
  always_comb begin
    exp_excp   = cmt_valid_i[0] & cmt_excp_valid_i;
    exp_refill = exp_excp & (cmt_ecode_i == TLBR);
    exp_ertn   = cmt_valid_i[0] & (cmt_kind_i == ERTN);
    // every kind other than a plain retire forces a flush
    exp_flush  = exp_excp | (cmt_valid_i[0] & (cmt_br_redirect_i | (cmt_kind_i != NORMAL)));
    exp_va     = exp_excp & va_cause(cmt_ecode_i);
    exp_tlb    = exp_va & (cmt_ecode_i != ADE) & (cmt_ecode_i != ALE);
    exp_era    = (cmt_ecode_i == SYS || cmt_ecode_i == BRK) ? cmt_pc_i[0] + 32'd4 : cmt_pc_i[0];
    if (exp_refill) begin
      exp_target = csr_tlbrentry_i;
    end else if (exp_excp) begin
      exp_target = csr_eentry_i;
    end else if (cmt_br_redirect_i) begin
      exp_target = cmt_br_target_i;
    end else if (exp_ertn) begin
      exp_target = csr_era_i;
    end else begin
      exp_target = cmt_pc_i[0] + 32'd4;
    end
    for (int s = 0; s < COMMIT_WIDTH; s++) begin
      exp_free[s] = cmt_valid_i[s] & (cmt_arch_reg_i[s] != '0);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      model_pc   <= RESET_PC;
      model_lock <= 1'b0;
      for (int i = 0; i < ARCH_REG_NUM; i++) begin
        model_rat[i] <= PREG_W'(i);
      end
    end else begin
      if (exp_flush) begin
        model_pc <= exp_target;
      end else if (!model_lock && fetch_ready_i) begin
        model_pc <= model_pc + FETCH_BYTES;
      end
      if (exp_flush && cmt_kind_i == IDLE && !csr_has_int_i) begin
        model_lock <= 1'b1;
      end else if (csr_has_int_i) begin
        model_lock <= 1'b0;
      end
      // slot 1 is younger and lands last
      for (int s = 0; s < COMMIT_WIDTH; s++) begin
        if (exp_free[s]) begin
          model_rat[cmt_arch_reg_i[s]] <= cmt_phy_reg_i[s];
        end
      end
    end
  end

  // ================================================
  // checks
  // ================================================
  a_flush: assert property (@(posedge clk) disable iff (!rst_n) flush_o == exp_flush)
    else flag_mismatch("flush_o does not follow the classification");
  a_target: assert property (@(posedge clk) disable iff (!rst_n)
    flush_o |=> fetch_pc_o == $past(exp_target))
    else flag_mismatch("fetch_pc_o is not the restart target after a flush");
  a_fetch_pc: assert property (@(posedge clk) disable iff (!rst_n) fetch_pc_o == model_pc)
    else flag_mismatch("fetch_pc_o differs from the expected address");
  a_fetch_valid: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_valid_o == !model_lock)
    else flag_mismatch("fetch_valid_o does not follow the idle lock");
  a_report: assert property (@(posedge clk) disable iff (!rst_n)
    cmt_valid_i[0] |-> era_o == exp_era && ecode_o == cmt_ecode_i
                       && bad_va_o == cmt_bad_vaddr_i)
    else flag_mismatch("era, ecode or bad address report wrong");
  a_report_flags: assert property (@(posedge clk) disable iff (!rst_n)
    excp_commit_o == exp_excp && tlbrefill_o == exp_refill && ertn_o == exp_ertn
    && va_error_o == exp_va && excp_tlb_o == exp_tlb)
    else flag_mismatch("exception flags wrong");
  a_free_valid: assert property (@(posedge clk) disable iff (!rst_n) free_valid_o == exp_free)
    else flag_mismatch("free_valid_o wrong");
  a_free_preg0: assert property (@(posedge clk) disable iff (!rst_n)
    free_valid_o[0] |-> free_preg_o[0] == cmt_old_phy_reg_i[0])
    else flag_mismatch("slot 0 freed register wrong");
  a_free_preg1: assert property (@(posedge clk) disable iff (!rst_n)
    free_valid_o[1] |-> free_preg_o[1] == cmt_old_phy_reg_i[1])
    else flag_mismatch("slot 1 freed register wrong");
  a_rat_read: assert property (@(posedge clk) disable iff (!rst_n)
    rat_rdata_o == model_rat[rat_raddr_i])
    else flag_mismatch("alias table read data wrong");

  // ================================================
  // stimulus
  // ================================================
  task automatic drive_quiet();
    cmt_valid_i       = '0;
    cmt_pc_i          = '0;
    cmt_arch_reg_i    = '0;
    cmt_phy_reg_i     = '0;
    cmt_old_phy_reg_i = '0;
    cmt_excp_valid_i  = 1'b0;
    cmt_ecode_i       = INT;
    cmt_br_redirect_i = 1'b0;
    cmt_br_target_i   = '0;
    cmt_kind_i        = NORMAL;
    cmt_bad_vaddr_i   = '0;
    csr_has_int_i     = 1'b0;
    fetch_ready_i     = 1'b0;
    rat_raddr_i       = ARCH_REG_W'($urandom);
  endtask

  // old mapping always differs from the new one
  task automatic fill_regs(input int s);
    cmt_pc_i[s]          = $urandom & 32'hffff_fffc;
    cmt_arch_reg_i[s]    = ARCH_REG_W'($urandom);
    cmt_phy_reg_i[s]     = PREG_W'($urandom);
    cmt_old_phy_reg_i[s] = cmt_phy_reg_i[s] ^ PREG_W'(1 + $urandom % 63);
  endtask

  task automatic seq_fetch_test();
    int len;
    for (int seg = 0; seg < 16; seg++) begin
      len = 1 + int'($urandom % 6);
      repeat (len) begin
        drive_quiet();
        fetch_ready_i = (seg % 2 == 0);
        @(negedge clk);
      end
    end
  endtask

  task automatic flush_test(input int n, input logic force_excp);
    repeat (n) begin
      drive_quiet();
      cmt_valid_i       = 2'b01;
      fill_regs(0);
      cmt_excp_valid_i  = force_excp | (($urandom % 4) == 0);
      cmt_ecode_i       = CAUSES[$urandom % 12];
      cmt_bad_vaddr_i   = $urandom;
      cmt_br_redirect_i = !force_excp && (($urandom % 4) == 0);
      cmt_br_target_i   = $urandom & 32'hffff_fffc;
      if (!force_excp && ($urandom % 2) == 1) begin
        cmt_kind_i = cmt_kind_e'(3'($urandom % 6));
      end
      csr_eentry_i      = $urandom & 32'hffff_fffc;
      csr_tlbrentry_i   = $urandom & 32'hffff_fffc;
      csr_era_i         = $urandom & 32'hffff_fffc;
      csr_has_int_i     = ($urandom % 4) == 0;
      fetch_ready_i     = 1'($urandom % 2);
      @(negedge clk);
    end
    // release any idle lock left behind
    drive_quiet();
    csr_has_int_i = 1'b1;
    @(negedge clk);
  endtask

  task automatic idle_test();
    logic [31:0] idle_pc;
    drive_quiet();
    cmt_valid_i = 2'b01;
    fill_regs(0);
    cmt_kind_i  = IDLE;
    idle_pc     = cmt_pc_i[0];
    @(negedge clk);
    repeat (20) begin
      drive_quiet();
      fetch_ready_i = 1'b1;
      @(negedge clk);
      assert (!fetch_valid_o && fetch_pc_o == idle_pc + 32'd4)
        else flag_mismatch("fetch did not stop at the instruction after idle");
    end
    csr_has_int_i = 1'b1;
    @(negedge clk);
    csr_has_int_i = 1'b0;
    while (!fetch_valid_o) begin
      @(negedge clk);
    end
    repeat (10) @(negedge clk);
  endtask

  task automatic rat_test();
    int pick;
    repeat (240) begin
      drive_quiet();
      fetch_ready_i = 1'($urandom % 2);
      pick          = int'($urandom % 4);
      cmt_valid_i   = (pick == 0) ? 2'b00 : (pick == 1) ? 2'b01 : 2'b11;
      fill_regs(0);
      fill_regs(1);
      // same destination in both slots, and writes to r0
      if ($urandom % 4 == 0) begin
        cmt_arch_reg_i[1] = cmt_arch_reg_i[0];
      end
      if ($urandom % 8 == 0) begin
        cmt_arch_reg_i[pick % 2] = '0;
      end
      @(negedge clk);
    end
  endtask

  initial begin
    void'($urandom(14920));
    drive_quiet();
    csr_eentry_i    = '0;
    csr_tlbrentry_i = '0;
    csr_era_i       = '0;
    rst_n = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (fetch_pc_o == RESET_PC && fetch_valid_o)
      else flag_mismatch("fetch state after reset");
    seq_fetch_test();
    flush_test(150, 1'b0);
    flush_test(100, 1'b1);
    idle_test();
    rat_test();
    repeat (4) @(negedge clk);
    $display("done: %0d errors in %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // run limit, roughly three times the test length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

endmodule

//--- verilog.f
hw/commit_pkg.sv
hw/commit_if.sv
hw/commit_flush_ctrl.sv
hw/fetch_pc_gen.sv
hw/arch_rat.sv
hw/commit_unit_top.sv
testbench/tb_commit_unit.sv
